/* include/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Width of the data path through the execute block.
// Operands, results and all shifter levels use this width.
`define ALU_WIDTH 16

// Width of the shift amount.
// The shifter takes it from the low bits of operand b.
// Three base-3 digits cover amounts 0 to 15 with this width.
`define SHAMT_WIDTH 4

`endif

/* hdl/alu_pkg.sv */
package alu_pkg;

  // Operation codes.
  // For shifts, the low two bits give the shift mode.
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_AND  = 3'd3,
    OP_SLL  = 3'd4,
    OP_SRA  = 3'd5,
    OP_ROR  = 3'd6,
    OP_RSVD = 3'd7
  } alu_op_t;

  // Shift modes.
  // The value 3 is not used.
  typedef enum logic [1:0] {
    SH_SLL = 2'd0,
    SH_SRA = 2'd1,
    SH_ROR = 2'd2
  } shift_mode_t;

  // Condition flags.
  // The same layout serves as a per-field write mask.
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

endpackage

/* hdl/shift_stage.sv */
`timescale 1ns/1ps

`include "alu_defines.svh"

module shift_stage #(
  parameter int DIST = 1
) (
  input  logic [`ALU_WIDTH-1:0] data_in,
  input  alu_pkg::shift_mode_t  mode,
  input  logic [1:0]            sel,
  output logic [`ALU_WIDTH-1:0] data_out
);

  import alu_pkg::*;

  localparam int W = `ALU_WIDTH;

  // Rotation distances folded into the word width.
  localparam int ROT1 = DIST % W;
  localparam int ROT2 = (2 * DIST) % W;

  logic [W-1:0] one_dist;
  logic [W-1:0] two_dist;

  // Candidate outputs for one and two times the level distance.
  always_comb begin
    case (mode)
      SH_SLL: begin
        one_dist = data_in << DIST;
        two_dist = data_in << (2 * DIST);
      end
      SH_SRA: begin
        one_dist = $signed(data_in) >>> DIST;
        two_dist = $signed(data_in) >>> (2 * DIST);
      end
      SH_ROR: begin
        // A zero rotation leaves the left term empty, so the word passes as is.
        one_dist = (data_in >> ROT1) | (data_in << (W - ROT1));
        two_dist = (data_in >> ROT2) | (data_in << (W - ROT2));
      end
      default: begin
        one_dist = data_in;
        two_dist = data_in;
      end
    endcase
  end

  // Three-way select on the base-3 digit.
  always_comb begin
    case (sel)
      2'd0:    data_out = data_in;
      2'd1:    data_out = one_dist;
      2'd2:    data_out = two_dist;
      default: data_out = data_in;
    endcase
  end

endmodule

/* hdl/barrel_shifter.sv */
`timescale 1ns/1ps

`include "alu_defines.svh"

module barrel_shifter (
  input  logic [`ALU_WIDTH-1:0]   data_in,
  input  logic [`SHAMT_WIDTH-1:0] shamt,
  input  alu_pkg::shift_mode_t    mode,
  output logic [`ALU_WIDTH-1:0]   data_out
);

  logic [1:0] sel_d0;
  logic [1:0] sel_d1;
  logic [1:0] sel_d2;

  logic [`ALU_WIDTH-1:0] stage1_out;
  logic [`ALU_WIDTH-1:0] stage3_out;

  // Base-3 digits of the shift amount, most significant digit first.
  always_comb begin
    case (shamt)
      4'd0:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd0, 2'd0};
      4'd1:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd0, 2'd1};
      4'd2:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd0, 2'd2};
      4'd3:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd1, 2'd0};
      4'd4:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd1, 2'd1};
      4'd5:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd1, 2'd2};
      4'd6:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd2, 2'd0};
      4'd7:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd2, 2'd1};
      4'd8:    {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd2, 2'd2};
      4'd9:    {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd0, 2'd0};
      4'd10:   {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd0, 2'd1};
      4'd11:   {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd0, 2'd2};
      4'd12:   {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd1, 2'd0};
      4'd13:   {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd1, 2'd1};
      4'd14:   {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd1, 2'd2};
      4'd15:   {sel_d2, sel_d1, sel_d0} = {2'd1, 2'd2, 2'd0};
      default: {sel_d2, sel_d1, sel_d0} = {2'd0, 2'd0, 2'd0};
    endcase
  end

  shift_stage #(.DIST(1)) u_stage_1 (
    .data_in  (data_in),
    .mode     (mode),
    .sel      (sel_d0),
    .data_out (stage1_out)
  );

  shift_stage #(.DIST(3)) u_stage_3 (
    .data_in  (stage1_out),
    .mode     (mode),
    .sel      (sel_d1),
    .data_out (stage3_out)
  );

  // The top digit never reaches 2 for amounts up to 15.
  shift_stage #(.DIST(9)) u_stage_9 (
    .data_in  (stage3_out),
    .mode     (mode),
    .sel      (sel_d2),
    .data_out (data_out)
  );

endmodule

/* hdl/sat_adder.sv */
`timescale 1ns/1ps

`include "alu_defines.svh"

module sat_adder (
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic                  sub,
  output logic [`ALU_WIDTH-1:0] sum,
  output logic                  ovf
);

  localparam int W = `ALU_WIDTH;

  localparam logic [W-1:0] SAT_MAX = {1'b0, {(W-1){1'b1}}};
  localparam logic [W-1:0] SAT_MIN = {1'b1, {(W-1){1'b0}}};

  logic [W-1:0] b_eff;
  logic [W-1:0] raw_sum;

  // Subtraction adds the inverted operand with a carry-in of one.
  assign b_eff   = sub ? ~b : b;
  assign raw_sum = a + b_eff + {{(W-1){1'b0}}, sub};

  // Overflow when both addends share a sign that the raw sum does not.
  assign ovf = (a[W-1] == b_eff[W-1]) && (raw_sum[W-1] != a[W-1]);

  always_comb begin
    if (ovf) begin
      // The sign of a tells which limit was crossed.
      sum = a[W-1] ? SAT_MIN : SAT_MAX;
    end else begin
      sum = raw_sum;
    end
  end

endmodule

/* hdl/alu_core.sv */
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_core (
  input  alu_pkg::alu_op_t      op,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  output logic [`ALU_WIDTH-1:0] y,
  output alu_pkg::flags_t       flags_new,
  output alu_pkg::flags_t       flags_upd
);

  import alu_pkg::*;

  localparam int W = `ALU_WIDTH;

  logic          is_sub;
  logic [W-1:0]  add_sum;
  logic          add_ovf;
  shift_mode_t   sh_mode;
  logic [W-1:0]  shift_out;

  assign is_sub = (op == OP_SUB);

  // Shift opcodes carry their mode in the low two bits.
  assign sh_mode = shift_mode_t'(op[1:0]);

  sat_adder u_sat_adder (
    .a   (a),
    .b   (b),
    .sub (is_sub),
    .sum (add_sum),
    .ovf (add_ovf)
  );

  barrel_shifter u_barrel_shifter (
    .data_in  (a),
    .shamt    (b[`SHAMT_WIDTH-1:0]),
    .mode     (sh_mode),
    .data_out (shift_out)
  );

  always_comb begin
    case (op)
      OP_ADD,
      OP_SUB:  y = add_sum;
      OP_XOR:  y = a ^ b;
      OP_AND:  y = a & b;
      OP_SLL,
      OP_SRA,
      OP_ROR:  y = shift_out;
      default: y = '0;
    endcase
  end

  // Candidate flags for every opcode; the mask decides which ones land.
  always_comb begin
    flags_new.z = (y == '0);
    flags_new.v = add_ovf;
    flags_new.n = y[W-1];
  end

  always_comb begin
    flags_upd = '0;
    case (op)
      OP_ADD,
      OP_SUB: begin
        flags_upd.z = 1'b1;
        flags_upd.v = 1'b1;
        flags_upd.n = 1'b1;
      end
      OP_XOR,
      OP_AND,
      OP_SLL,
      OP_SRA,
      OP_ROR: begin
        flags_upd.z = 1'b1;
      end
      default: begin
        // Reserved opcode leaves every flag alone.
        flags_upd = '0;
      end
    endcase
  end

endmodule

/* hdl/alu_exec_top.sv */
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_exec_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  alu_pkg::alu_op_t      op,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  output logic                  out_valid,
  output logic [`ALU_WIDTH-1:0] result,
  output alu_pkg::flags_t       flags
);

  import alu_pkg::*;

  logic [`ALU_WIDTH-1:0] core_y;
  flags_t                core_flags;
  flags_t                core_upd;

  alu_core u_alu_core (
    .op        (op),
    .a         (a),
    .b         (b),
    .y         (core_y),
    .flags_new (core_flags),
    .flags_upd (core_upd)
  );

  // Output stage with a one-cycle valid pulse per strobe.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        result <= core_y;
      end
    end
  end

  // Each flag field is written only when its mask bit is set.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (in_valid) begin
      if (core_upd.z) begin
        flags.z <= core_flags.z;
      end
      if (core_upd.v) begin
        flags.v <= core_flags.v;
      end
      if (core_upd.n) begin
        flags.n <= core_flags.n;
      end
    end
  end

endmodule

/* test/alu_exec_tb.sv */
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_exec_tb;

  import alu_pkg::*;

  localparam int W               = `ALU_WIDTH;
  localparam int CLK_PERIOD      = 4;
  localparam int N_RANDOM        = 400;
  localparam int TOTAL_OPS       = 8 + 6 + 96 + N_RANDOM;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 4 + 100;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  alu_op_t      op;
  logic [W-1:0] a;
  logic [W-1:0] b;
  logic         out_valid;
  logic [W-1:0] result;
  flags_t       flags;

  // Model flags at issue time and the values the output register should show.
  flags_t       model_flags;
  logic [W-1:0] shown_result;
  flags_t       shown_flags;
  logic [W-1:0] exp_results[$];
  flags_t       exp_flags_q[$];

  int errors;
  int errors_at_start;
  int tests_passed;
  int tests_failed;

  alu_exec_top alu_exec_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed.");
    $display("STATUS: FAIL");
    $finish;
  end

  // Each strobe gives exactly one pulse one cycle later.
  assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid))
    else begin
      $display("out_valid did not follow in_valid by one cycle at %0t", $time);
      errors++;
    end

  function automatic logic [W-1:0] shift_model(alu_op_t o, logic [W-1:0] v_in,
                                               logic [W-1:0] amt_in);
    logic [W-1:0] v;
    int           amt;
    v   = v_in;
    amt = {28'd0, amt_in[3:0]};
    for (int i = 0; i < amt; i++) begin
      case (o)
        OP_SLL:  v = {v[W-2:0], 1'b0};
        OP_SRA:  v = {v[W-1], v[W-1:1]};
        default: v = {v[0], v[W-1:1]};
      endcase
    end
    return v;
  endfunction

  function automatic logic expected_overflow(alu_op_t o, logic [W-1:0] x, logic [W-1:0] y);
    int s;
    if (o == OP_ADD) begin
      s = int'(signed'(x)) + int'(signed'(y));
    end else if (o == OP_SUB) begin
      s = int'(signed'(x)) - int'(signed'(y));
    end else begin
      return 1'b0;
    end
    return (s > 32767) || (s < -32768);
  endfunction

  function automatic logic [W-1:0] expected_result(alu_op_t o, logic [W-1:0] x,
                                                   logic [W-1:0] y);
    int s;
    case (o)
      OP_ADD, OP_SUB: begin
        if (o == OP_ADD) begin
          s = int'(signed'(x)) + int'(signed'(y));
        end else begin
          s = int'(signed'(x)) - int'(signed'(y));
        end
        if (s > 32767) begin
          return 16'h7FFF;
        end else if (s < -32768) begin
          return 16'h8000;
        end
        return s[W-1:0];
      end
      OP_XOR:                 return x ^ y;
      OP_AND:                 return x & y;
      OP_SLL, OP_SRA, OP_ROR: return shift_model(o, x, y);
      default:                return 16'h0000;
    endcase
  endfunction

  function automatic flags_t next_flags(alu_op_t o, logic [W-1:0] r, logic ovf, flags_t old);
    flags_t f;
    f = old;
    case (o)
      OP_ADD, OP_SUB: begin
        f.z = (r == 16'h0000);
        f.v = ovf;
        f.n = r[W-1];
      end
      OP_RSVD: begin
        f = old;
      end
      default: begin
        f.z = (r == 16'h0000);
      end
    endcase
    return f;
  endfunction

  task automatic check_outputs();
    logic exp_valid;
    exp_valid = (exp_results.size() != 0);
    if (exp_valid) begin
      shown_result = exp_results.pop_front();
      shown_flags  = exp_flags_q.pop_front();
    end
    assert (out_valid === exp_valid) else begin
      $display("MISMATCH out_valid expected %h actual %h", exp_valid, out_valid);
      errors++;
    end
    assert (result === shown_result) else begin
      $display("MISMATCH result expected %h actual %h", shown_result, result);
      errors++;
    end
    assert (flags === shown_flags) else begin
      $display("MISMATCH flags expected %h actual %h", shown_flags, flags);
      errors++;
    end
  endtask

  task automatic issue(alu_op_t op_i, logic [W-1:0] a_i, logic [W-1:0] b_i);
    logic [W-1:0] r;
    flags_t       f;
    @(negedge clk);
    check_outputs();
    r = expected_result(op_i, a_i, b_i);
    f = next_flags(op_i, r, expected_overflow(op_i, a_i, b_i), model_flags);
    model_flags = f;
    exp_results.push_back(r);
    exp_flags_q.push_back(f);
    in_valid = 1'b1;
    op       = op_i;
    a        = a_i;
    b        = b_i;
  endtask

  task automatic idle();
    @(negedge clk);
    check_outputs();
    in_valid = 1'b0;
    // Idle cycles carry fresh operands that the output stage must ignore.
    op = alu_op_t'(3'($urandom_range(0, 7)));
    a  = 16'($urandom);
    b  = 16'($urandom);
  endtask

  task automatic finish_test(string name);
    idle();
    idle();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  alu_op_t      shift_ops[3] = '{OP_SLL, OP_SRA, OP_ROR};
  logic [W-1:0] patterns[2]  = '{16'hB38D, 16'h4C72};

  initial begin
    // A strobe during the first reset cycle must not reach the outputs.
    in_valid        = 1'b1;
    op              = OP_ADD;
    a               = 16'h7000;
    b               = 16'h2000;
    rst_n           = 1'b0;
    model_flags     = '0;
    shown_result    = '0;
    shown_flags     = '0;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    void'($urandom(32'h7804_1524));

    // Outputs are checked inside reset and once after it.
    @(posedge clk);
    @(negedge clk);
    check_outputs();
    in_valid = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_outputs();
    rst_n = 1'b1;
    finish_test("reset_state");

    issue(OP_ADD, 16'h7000, 16'h2000);
    issue(OP_ADD, 16'h8000, 16'hFFFF);
    issue(OP_SUB, 16'h8000, 16'h0001);
    issue(OP_SUB, 16'h7FFF, 16'hFFFF);
    issue(OP_ADD, 16'h1234, 16'hEDCC);
    issue(OP_SUB, 16'h0005, 16'h0005);
    issue(OP_SUB, 16'h0003, 16'h0008);
    issue(OP_ADD, 16'hFF00, 16'h0010);
    finish_test("saturating_arithmetic");

    // A negative overflow sets v and n before the logic operations run.
    issue(OP_ADD, 16'h8000, 16'h8000);
    issue(OP_XOR, 16'h00FF, 16'h00FF);
    issue(OP_AND, 16'hF0F0, 16'h0F0F);
    issue(OP_XOR, 16'h1234, 16'h0000);
    issue(OP_AND, 16'hFFFF, 16'h8001);
    issue(OP_RSVD, 16'hFFFF, 16'hFFFF);
    finish_test("logic_and_flag_hold");

    foreach (shift_ops[m]) begin
      foreach (patterns[p]) begin
        for (int k = 0; k < 16; k++) begin
          issue(shift_ops[m], patterns[p], 16'(k));
        end
      end
    end
    finish_test("shifts");

    for (int i = 0; i < N_RANDOM; i++) begin
      issue(alu_op_t'(3'($urandom_range(0, 7))), 16'($urandom), 16'($urandom));
      if ($urandom_range(0, 3) == 0) begin
        repeat ($urandom_range(1, 3)) idle();
      end
    end
    finish_test("random_stream");

    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hdl/alu_pkg.sv
hdl/shift_stage.sv
hdl/barrel_shifter.sv
hdl/sat_adder.sv
hdl/alu_core.sv
hdl/alu_exec_top.sv
test/alu_exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= alu_exec_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
